//--- common/dacfifo_pkg.sv
// ***********************************************************
// widths and ratios of the dac sample buffer write side
// ***********************************************************

package dacfifo_pkg;

  // one dma beat and one memory word
  localparam int dma_data_width = 64;
  localparam int avl_data_width = 256;

  // beats packed into each memory word
  localparam int mem_ratio = avl_data_width / dma_data_width;
  localparam int beat_index_width = 2;

  localparam int avl_byte_width = avl_data_width / 8;
  localparam int dma_byte_width = dma_data_width / 8;
  localparam int avl_address_width = 25;

  // fill count, enough for buffers of up to 16 words
  localparam int buf_level_width = 5;

  typedef logic [dma_data_width-1:0] dma_data_t;
  typedef logic [avl_data_width-1:0] avl_data_t;
  typedef logic [avl_address_width-1:0] avl_addr_t;
  typedef logic [avl_byte_width-1:0] avl_be_t;
  typedef logic [beat_index_width-1:0] beat_index_t;
  typedef logic [buf_level_width-1:0] buf_level_t;

  // avalon write engine states
  typedef enum logic [1:0] {
    idle,
    fetch,
    write,
    finish
  } engine_state_t;

endpackage

//--- beat_packer/beat_packer.sv
`timescale 1ns/1ps

module beat_packer #(
  parameter int buf_depth = 8
) (
  input  logic                     avl_clk,
  input  logic                     avl_reset,
  input  dacfifo_pkg::dma_data_t   dma_data,
  input  logic                     dma_valid,
  input  logic                     dma_xfer_req,
  input  logic                     dma_xfer_last,
  input  dacfifo_pkg::buf_level_t  level,
  output logic                     dma_ready,
  output logic                     word_push,
  output dacfifo_pkg::avl_data_t   push_word,
  output logic                     push_last,
  output dacfifo_pkg::beat_index_t push_last_beats
);

  localparam dacfifo_pkg::beat_index_t last_index =
    dacfifo_pkg::beat_index_t'(dacfifo_pkg::mem_ratio - 1);

  logic                     accept;
  logic                     commit;
  dacfifo_pkg::beat_index_t beat_index;
  dacfifo_pkg::avl_data_t   pack_word;
  dacfifo_pkg::avl_data_t   next_word;

  assign accept = dma_valid & dma_ready & dma_xfer_req;

  // word is complete when it is full or the transfer ends
  assign commit = accept & (dma_xfer_last | (beat_index == last_index));

  // drop the new beat into its slot, beat 0 in the low bits
  always_comb begin
    next_word = pack_word;
    next_word[beat_index*dacfifo_pkg::dma_data_width +: dacfifo_pkg::dma_data_width] = dma_data;
  end

  // ***********************************************************
  // beat index, push strobe and dma throttle
  // ***********************************************************

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      beat_index <= '0;
      word_push <= 1'b0;
      dma_ready <= 1'b0;
    end else begin
      word_push <= commit;
      // leave room for the words still in flight
      dma_ready <= dma_xfer_req && (int'(level) < buf_depth - 2);
      if (!dma_xfer_req || commit) begin
        beat_index <= '0;
      end else if (accept) begin
        beat_index <= beat_index + 1'b1;
      end
    end
  end

  // accumulator starts each word at zero, so unfilled beats stay clear
  always_ff @(posedge avl_clk) begin
    if (!dma_xfer_req || commit) begin
      pack_word <= '0;
    end else if (accept) begin
      pack_word <= next_word;
    end
  end

  always_ff @(posedge avl_clk) begin
    if (commit) begin
      push_word <= next_word;
      push_last <= dma_xfer_last;
      push_last_beats <= beat_index;
    end
  end

  // the throttle must keep the buffer from overflowing
  assert property (@(posedge avl_clk) disable iff (avl_reset)
    !(word_push && (int'(level) == buf_depth)))
    else $error("word pushed into a full buffer");

endmodule

//--- beat_packer/word_buffer.sv
`timescale 1ns/1ps

module word_buffer #(
  parameter int buf_depth = 8
) (
  input  logic                     avl_clk,
  input  logic                     avl_reset,
  input  logic                     word_push,
  input  dacfifo_pkg::avl_data_t   push_word,
  input  logic                     push_last,
  input  dacfifo_pkg::beat_index_t push_last_beats,
  input  logic                     word_pop,
  output dacfifo_pkg::buf_level_t  level,
  output logic                     buf_empty,
  output dacfifo_pkg::avl_data_t   head_word,
  output logic                     head_last,
  output dacfifo_pkg::beat_index_t head_last_beats
);

  localparam int ptr_width = (buf_depth > 1) ? $clog2(buf_depth) : 1;

  // word store with its last tag alongside
  dacfifo_pkg::avl_data_t   word_mem  [buf_depth];
  logic                     last_mem  [buf_depth];
  dacfifo_pkg::beat_index_t beats_mem [buf_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;

  assign buf_empty = (level == '0);

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level <= '0;
    end else begin
      if (word_push) begin
        wr_ptr <= (int'(wr_ptr) == buf_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (word_pop) begin
        rd_ptr <= (int'(rd_ptr) == buf_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      level <= level + dacfifo_pkg::buf_level_t'(word_push)
                     - dacfifo_pkg::buf_level_t'(word_pop);
    end
  end

  always_ff @(posedge avl_clk) begin
    if (word_push) begin
      word_mem[wr_ptr] <= push_word;
      last_mem[wr_ptr] <= push_last;
      beats_mem[wr_ptr] <= push_last_beats;
    end
  end

  // head entry is valid the cycle after the pop
  always_ff @(posedge avl_clk) begin
    if (word_pop) begin
      head_word <= word_mem[rd_ptr];
      head_last <= last_mem[rd_ptr];
      head_last_beats <= beats_mem[rd_ptr];
    end
  end

  assert property (@(posedge avl_clk) disable iff (avl_reset) !(word_pop && buf_empty))
    else $error("pop from an empty word buffer");

endmodule

//--- source/avl_write_engine.sv
`timescale 1ns/1ps

module avl_write_engine #(
  parameter int avl_ddr_base_address = 0,
  parameter int avl_ddr_address_limit = 1048575
) (
  input  logic                   avl_clk,
  input  logic                   avl_reset,
  input  logic                   dma_xfer_req,
  input  logic                   buf_empty,
  input  dacfifo_pkg::avl_data_t head_word,
  input  logic                   head_last,
  input  logic                   avl_ready,
  input  dacfifo_pkg::avl_be_t   byteenable,
  output logic                   word_pop,
  output dacfifo_pkg::avl_addr_t avl_address,
  output dacfifo_pkg::avl_data_t avl_data,
  output dacfifo_pkg::avl_be_t   avl_byteenable,
  output logic                   avl_write,
  output logic                   write_accept,
  output logic                   write_last
);

  localparam dacfifo_pkg::avl_addr_t base_addr =
    dacfifo_pkg::avl_addr_t'(avl_ddr_base_address);
  localparam dacfifo_pkg::avl_addr_t limit_addr =
    dacfifo_pkg::avl_addr_t'(avl_ddr_address_limit);

  dacfifo_pkg::engine_state_t state;
  logic                       xfer_req_d;
  logic                       xfer_rise;
  dacfifo_pkg::avl_addr_t     next_address;

  assign xfer_rise = dma_xfer_req & ~xfer_req_d;
  assign write_accept = avl_write & avl_ready;

  // pop from idle, or right at the accept of a word that is not the last
  assign word_pop = ~buf_empty &
                    ((state == dacfifo_pkg::idle) | (write_accept & ~write_last));

  // wrap from the limit back to the base
  assign next_address = (avl_address == limit_addr) ? base_addr : avl_address + 1'b1;

  // ***********************************************************
  // write state machine
  // ***********************************************************

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      state <= dacfifo_pkg::idle;
      avl_write <= 1'b0;
      write_last <= 1'b0;
      avl_address <= base_addr;
      xfer_req_d <= 1'b0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      case (state)
        dacfifo_pkg::idle: begin
          if (xfer_rise) begin
            avl_address <= base_addr;
          end
          if (!buf_empty) begin
            state <= dacfifo_pkg::fetch;
          end
        end
        dacfifo_pkg::fetch: begin
          // head entry is registered by now
          avl_write <= 1'b1;
          write_last <= head_last;
          state <= dacfifo_pkg::write;
        end
        dacfifo_pkg::write: begin
          if (avl_ready) begin
            avl_write <= 1'b0;
            avl_address <= next_address;
            if (write_last) begin
              state <= dacfifo_pkg::finish;
            end else if (!buf_empty) begin
              state <= dacfifo_pkg::fetch;
            end else begin
              state <= dacfifo_pkg::idle;
            end
          end
        end
        dacfifo_pkg::finish: begin
          // transfer is in memory, wait for the next session
          if (xfer_rise) begin
            avl_address <= base_addr;
            state <= dacfifo_pkg::idle;
          end
        end
        default: state <= dacfifo_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge avl_clk) begin
    if (state == dacfifo_pkg::fetch) begin
      avl_data <= head_word;
      avl_byteenable <= byteenable;
    end
  end

  // a stalled write holds its whole command
  assert property (@(posedge avl_clk) disable iff (avl_reset)
    (avl_write && !avl_ready) |=>
      (state == dacfifo_pkg::write) && avl_write && $stable(avl_address) &&
      $stable(avl_data) && $stable(avl_byteenable))
    else $error("avalon write changed while stalled");

endmodule

//--- source/xfer_status.sv
`timescale 1ns/1ps

module xfer_status (
  input  logic                     avl_clk,
  input  logic                     avl_reset,
  input  logic                     dma_xfer_req,
  input  logic                     head_last,
  input  dacfifo_pkg::beat_index_t head_last_beats,
  input  logic                     write_accept,
  input  logic                     write_last,
  input  dacfifo_pkg::avl_addr_t   avl_address,
  output dacfifo_pkg::avl_be_t     byteenable,
  output dacfifo_pkg::avl_addr_t   avl_last_address,
  output dacfifo_pkg::avl_be_t     avl_last_byteenable,
  output logic                     avl_xfer_req
);

  dacfifo_pkg::avl_be_t last_be;
  logic                 xfer_req_d;
  logic                 xfer_rise;

  assign xfer_rise = dma_xfer_req & ~xfer_req_d;

  // enable the bytes of every beat up to the final one
  always_comb begin
    for (int i = 0; i < dacfifo_pkg::mem_ratio; i++) begin
      last_be[i*dacfifo_pkg::dma_byte_width +: dacfifo_pkg::dma_byte_width] =
        (i <= int'(head_last_beats)) ? '1 : '0;
    end
  end

  // head entry stays put until the write is accepted
  assign byteenable = head_last ? last_be : '1;

  // ***********************************************************
  // last word record and done flag
  // ***********************************************************

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      xfer_req_d <= 1'b0;
      avl_xfer_req <= 1'b0;
      avl_last_address <= '0;
      avl_last_byteenable <= '0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      if (write_accept && write_last) begin
        avl_last_address <= avl_address;
        avl_last_byteenable <= byteenable;
        avl_xfer_req <= 1'b1;
      end else if (xfer_rise) begin
        // a new session invalidates the memory contents
        avl_xfer_req <= 1'b0;
      end
    end
  end

endmodule

//--- source/dacfifo_wr_top.sv
`timescale 1ns/1ps

module dacfifo_wr_top #(
  parameter int avl_ddr_base_address = 0,
  parameter int avl_ddr_address_limit = 1048575,
  parameter int buf_depth = 8
) (
  input  logic                   avl_clk,
  input  logic                   avl_reset,

  input  dacfifo_pkg::dma_data_t dma_data,
  input  logic                   dma_valid,
  input  logic                   dma_xfer_req,
  input  logic                   dma_xfer_last,
  output logic                   dma_ready,

  output dacfifo_pkg::avl_addr_t avl_address,
  output dacfifo_pkg::avl_data_t avl_data,
  output dacfifo_pkg::avl_be_t   avl_byteenable,
  output logic                   avl_write,
  input  logic                   avl_ready,

  output dacfifo_pkg::avl_addr_t avl_last_address,
  output dacfifo_pkg::avl_be_t   avl_last_byteenable,
  output logic                   avl_xfer_req
);

  // packer to buffer
  logic                     word_push;
  dacfifo_pkg::avl_data_t   push_word;
  logic                     push_last;
  dacfifo_pkg::beat_index_t push_last_beats;
  dacfifo_pkg::buf_level_t  level;

  // buffer to engine and status
  logic                     word_pop;
  logic                     buf_empty;
  dacfifo_pkg::avl_data_t   head_word;
  logic                     head_last;
  dacfifo_pkg::beat_index_t head_last_beats;

  // engine and status
  logic                     write_accept;
  logic                     write_last;
  dacfifo_pkg::avl_be_t     byteenable;

  beat_packer #(
    .buf_depth (buf_depth)
  ) u_beat_packer (
    .avl_clk         (avl_clk),
    .avl_reset       (avl_reset),
    .dma_data        (dma_data),
    .dma_valid       (dma_valid),
    .dma_xfer_req    (dma_xfer_req),
    .dma_xfer_last   (dma_xfer_last),
    .level           (level),
    .dma_ready       (dma_ready),
    .word_push       (word_push),
    .push_word       (push_word),
    .push_last       (push_last),
    .push_last_beats (push_last_beats)
  );

  word_buffer #(
    .buf_depth (buf_depth)
  ) u_word_buffer (
    .avl_clk         (avl_clk),
    .avl_reset       (avl_reset),
    .word_push       (word_push),
    .push_word       (push_word),
    .push_last       (push_last),
    .push_last_beats (push_last_beats),
    .word_pop        (word_pop),
    .level           (level),
    .buf_empty       (buf_empty),
    .head_word       (head_word),
    .head_last       (head_last),
    .head_last_beats (head_last_beats)
  );

  avl_write_engine #(
    .avl_ddr_base_address  (avl_ddr_base_address),
    .avl_ddr_address_limit (avl_ddr_address_limit)
  ) u_avl_write_engine (
    .avl_clk        (avl_clk),
    .avl_reset      (avl_reset),
    .dma_xfer_req   (dma_xfer_req),
    .buf_empty      (buf_empty),
    .head_word      (head_word),
    .head_last      (head_last),
    .avl_ready      (avl_ready),
    .byteenable     (byteenable),
    .word_pop       (word_pop),
    .avl_address    (avl_address),
    .avl_data       (avl_data),
    .avl_byteenable (avl_byteenable),
    .avl_write      (avl_write),
    .write_accept   (write_accept),
    .write_last     (write_last)
  );

  xfer_status u_xfer_status (
    .avl_clk             (avl_clk),
    .avl_reset           (avl_reset),
    .dma_xfer_req        (dma_xfer_req),
    .head_last           (head_last),
    .head_last_beats     (head_last_beats),
    .write_accept        (write_accept),
    .write_last          (write_last),
    .avl_address         (avl_address),
    .byteenable          (byteenable),
    .avl_last_address    (avl_last_address),
    .avl_last_byteenable (avl_last_byteenable),
    .avl_xfer_req        (avl_xfer_req)
  );

endmodule

//--- testbench/tb_checks.svh
`ifndef tb_checks_svh
`define tb_checks_svh

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

task automatic word_check(input string name, input dacfifo_pkg::avl_data_t got,
                          input dacfifo_pkg::avl_data_t expected);
  if (got !== expected) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    test_errors++;
  end
endtask

task automatic address_check(input string name, input dacfifo_pkg::avl_addr_t got,
                             input dacfifo_pkg::avl_addr_t expected);
  if (got !== expected) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    test_errors++;
  end
endtask

task automatic byteenable_check(input string name, input dacfifo_pkg::avl_be_t got,
                                input dacfifo_pkg::avl_be_t expected);
  if (got !== expected) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    test_errors++;
  end
endtask

task automatic flag_check(input string name, input logic got, input logic expected);
  if (got !== expected) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    test_errors++;
  end
endtask

`endif

//--- testbench/tb_dacfifo_wr.sv
`timescale 1ns/1ps

module tb_dacfifo_wr;

  localparam int ddr_base = 0;
  localparam int ddr_limit = 1048575;
  localparam int buf_depth = 8;
  localparam int max_tests = 32;
  localparam int max_beats = 256;
  localparam int beat_timeout = 2000;
  localparam int done_timeout = 5000;

  logic                   avl_clk;
  logic                   avl_reset;
  dacfifo_pkg::dma_data_t dma_data;
  logic                   dma_valid;
  logic                   dma_xfer_req;
  logic                   dma_xfer_last;
  logic                   dma_ready;
  dacfifo_pkg::avl_addr_t avl_address;
  dacfifo_pkg::avl_data_t avl_data;
  dacfifo_pkg::avl_be_t   avl_byteenable;
  logic                   avl_write;
  logic                   avl_ready;
  dacfifo_pkg::avl_addr_t avl_last_address;
  dacfifo_pkg::avl_be_t   avl_last_byteenable;
  logic                   avl_xfer_req;

  logic [31:0]            lfsr_state;
  logic [31:0]            vec_mem [0:max_tests*5-1];
  dacfifo_pkg::dma_data_t beats [0:max_beats-1];

  // memory model keeps one entry per accepted write
  dacfifo_pkg::avl_addr_t wr_addr_q [$];
  dacfifo_pkg::avl_data_t wr_data_q [$];
  dacfifo_pkg::avl_be_t   wr_be_q [$];

  dacfifo_pkg::avl_addr_t held_addr;
  dacfifo_pkg::avl_data_t held_data;
  dacfifo_pkg::avl_be_t   held_be;
  bit                     held_valid;

  int test_errors;
  int global_errors;
  int proto_errors;
  int pass_count;
  int fail_count;
  int stall_pct;
  int ready_draw;
  int vec_index;
  bit stall_active;
  bit aborted;

  `include "tb_checks.svh"

  dacfifo_wr_top #(
    .avl_ddr_base_address  (ddr_base),
    .avl_ddr_address_limit (ddr_limit),
    .buf_depth             (buf_depth)
  ) u_dacfifo_wr_top (
    .avl_clk             (avl_clk),
    .avl_reset           (avl_reset),
    .dma_data            (dma_data),
    .dma_valid           (dma_valid),
    .dma_xfer_req        (dma_xfer_req),
    .dma_xfer_last       (dma_xfer_last),
    .dma_ready           (dma_ready),
    .avl_address         (avl_address),
    .avl_data            (avl_data),
    .avl_byteenable      (avl_byteenable),
    .avl_write           (avl_write),
    .avl_ready           (avl_ready),
    .avl_last_address    (avl_last_address),
    .avl_last_byteenable (avl_last_byteenable),
    .avl_xfer_req        (avl_xfer_req)
  );

  // one lfsr step per bit with the newest bit in the lsb
  function automatic logic [63:0] take_bits(input int count);
    logic [63:0] value;
    value = '0;
    for (int b = 0; b < count; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[62:0], lfsr_state[0]};
    end
    return value;
  endfunction

  initial begin
    avl_clk = 1'b0;
    forever #50 avl_clk = ~avl_clk;
  end

  // avl_ready stalls
  initial begin
    avl_ready = 1'b1;
    forever begin
      @(posedge avl_clk);
      #10;
      if (stall_active) begin
        ready_draw = int'(take_bits(8));
        avl_ready = ((ready_draw * 100) / 256 >= stall_pct);
      end else begin
        avl_ready = 1'b1;
      end
    end
  end

  // ************************************************************
  // memory model and write protocol monitor
  // ************************************************************

  always @(negedge avl_clk) begin
    if (avl_reset) begin
      held_valid = 1'b0;
    end else if (avl_write) begin
      if (held_valid && (avl_address !== held_addr || avl_data !== held_data ||
                         avl_byteenable !== held_be)) begin
        $display("write command at address %h changed while avl_ready was low", held_addr);
        proto_errors++;
      end
      if (avl_ready) begin
        wr_addr_q.push_back(avl_address);
        wr_data_q.push_back(avl_data);
        wr_be_q.push_back(avl_byteenable);
        held_valid = 1'b0;
      end else begin
        held_valid = 1'b1;
        held_addr = avl_address;
        held_data = avl_data;
        held_be = avl_byteenable;
      end
    end else begin
      if (held_valid) begin
        $display("avl_write dropped at address %h before avl_ready took it", held_addr);
        proto_errors++;
      end
      held_valid = 1'b0;
    end
  end

  // offer beats until each is taken; sample dma_ready mid cycle
  task automatic send_beats(input int n, output bit throttled, output bit timed_out);
    int i;
    int wait_cycles;
    i = 0;
    wait_cycles = 0;
    throttled = 1'b0;
    timed_out = 1'b0;
    while (i < n && !timed_out) begin
      @(posedge avl_clk);
      #10;
      dma_valid = 1'b1;
      dma_data = beats[i];
      dma_xfer_last = (i == n - 1);
      #40;
      if (dma_ready) begin
        i++;
        wait_cycles = 0;
      end else begin
        if (i > 0) throttled = 1'b1;
        wait_cycles++;
        if (wait_cycles > beat_timeout) begin
          timed_out = 1'b1;
          $display("beat %0d was not accepted within %0d cycles", i, beat_timeout);
        end
      end
    end
    @(posedge avl_clk);
    #10;
    dma_valid = 1'b0;
    dma_xfer_last = 1'b0;
    dma_data = '0;
  endtask

  task automatic wait_for_done(output bit timed_out);
    int cycles;
    cycles = 0;
    timed_out = 1'b0;
    @(negedge avl_clk);
    while (!avl_xfer_req && !timed_out) begin
      @(negedge avl_clk);
      cycles++;
      if (cycles > done_timeout) timed_out = 1'b1;
    end
    if (timed_out) begin
      $display("avl_xfer_req did not rise within %0d cycles of the last beat", done_timeout);
    end
  endtask

  task automatic run_transfer(input int t);
    int n;
    int words;
    int nbytes;
    int k;
    int j;
    int proto_base;
    bit throttled;
    bit timed_out;
    logic [31:0] seed;
    dacfifo_pkg::avl_data_t exp_word;
    dacfifo_pkg::avl_be_t exp_be;
    n = int'(vec_mem[t*5]);
    seed = vec_mem[t*5+1];
    test_errors = 0;
    if (n > max_beats) n = max_beats;
    @(posedge avl_clk);
    #30;
    // done flag of the previous session is still up
    if (t > 0) flag_check("avl_xfer_req before the session", avl_xfer_req, 1'b1);
    lfsr_state = lfsr_state ^ seed;
    if (lfsr_state == 32'h0) lfsr_state = 32'h9b04;
    for (k = 0; k < n; k++) begin
      beats[k] = take_bits(dacfifo_pkg::dma_data_width);
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_be_q.delete();
    proto_base = proto_errors;
    stall_pct = int'(vec_mem[t*5+2]);
    stall_active = 1'b1;
    @(posedge avl_clk);
    #10;
    dma_xfer_req = 1'b1;
    @(posedge avl_clk);
    #10;
    flag_check("avl_xfer_req after the session start", avl_xfer_req, 1'b0);
    send_beats(n, throttled, timed_out);
    dma_xfer_req = 1'b0;
    words = (n + dacfifo_pkg::mem_ratio - 1) / dacfifo_pkg::mem_ratio;
    if (!timed_out) wait_for_done(timed_out);
    if (timed_out) begin
      aborted = 1'b1;
      test_errors++;
    end else begin
      // every word is in memory by the time the done flag rises
      if (wr_data_q.size() != words) begin
        $display("avl_xfer_req rose with %0d of %0d words written", wr_data_q.size(), words);
        test_errors++;
      end
      // any write in this quiet period is a stray one
      repeat (8) @(posedge avl_clk);
      #30;
      stall_active = 1'b0;
      if (wr_data_q.size() != words) begin
        $display("expected %0d writes to memory, saw %0d", words, wr_data_q.size());
        test_errors++;
      end
      for (k = 0; k < words && k < wr_data_q.size(); k++) begin
        exp_word = '0;
        for (j = 0; j < dacfifo_pkg::mem_ratio; j++) begin
          if (k * dacfifo_pkg::mem_ratio + j < n) begin
            exp_word[j*dacfifo_pkg::dma_data_width +: dacfifo_pkg::dma_data_width] =
              beats[k*dacfifo_pkg::mem_ratio+j];
          end
        end
        exp_be = '1;
        if (k == words - 1) begin
          nbytes = ((n - 1) % dacfifo_pkg::mem_ratio + 1) * dacfifo_pkg::dma_byte_width;
          for (j = 0; j < dacfifo_pkg::avl_byte_width; j++) begin
            exp_be[j] = (j < nbytes);
          end
        end
        address_check($sformatf("avl_address of word %0d", k), wr_addr_q[k],
                      dacfifo_pkg::avl_addr_t'(ddr_base + k));
        word_check($sformatf("avl_data of word %0d", k), wr_data_q[k], exp_word);
        byteenable_check($sformatf("avl_byteenable of word %0d", k), wr_be_q[k], exp_be);
      end
      address_check("avl_last_address", avl_last_address,
                    dacfifo_pkg::avl_addr_t'(vec_mem[t*5+3]));
      byteenable_check("avl_last_byteenable", avl_last_byteenable,
                       dacfifo_pkg::avl_be_t'(vec_mem[t*5+4]));
      if (stall_pct >= 80 && n >= 48 && !throttled) begin
        $display("dma_ready never dropped under heavy avl_ready stalls");
        test_errors++;
      end
    end
    test_errors += proto_errors - proto_base;
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0d passed: %0d beats, %0d%% stalls", t, n, stall_pct);
    end else begin
      fail_count++;
      $display("test %0d failed: %0d beats, %0d%% stalls, %0d errors",
               t, n, stall_pct, test_errors);
    end
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    avl_reset = 1'b1;
    dma_data = '0;
    dma_valid = 1'b0;
    dma_xfer_req = 1'b0;
    dma_xfer_last = 1'b0;
    stall_active = 1'b0;
    stall_pct = 0;
    lfsr_state = 32'h9b04;
    held_valid = 1'b0;
    aborted = 1'b0;
    test_errors = 0;
    global_errors = 0;
    proto_errors = 0;
    pass_count = 0;
    fail_count = 0;
    for (int a = 0; a < max_tests * 5; a++) vec_mem[a] = '0;
    $readmemh("testbench/dacfifo_vectors.txt", vec_mem);

    repeat (3) @(posedge avl_clk);
    #10;
    avl_reset = 1'b0;
    @(posedge avl_clk);
    #30;
    flag_check("avl_xfer_req after reset", avl_xfer_req, 1'b0);
    flag_check("avl_write after reset", avl_write, 1'b0);
    flag_check("dma_ready after reset", dma_ready, 1'b0);
    global_errors += test_errors;

    vec_index = 0;
    while (vec_index < max_tests && vec_mem[vec_index*5] != 32'h0 && !aborted) begin
      run_transfer(vec_index);
      vec_index++;
    end
    if (vec_index == 0) $display("no test vectors were read");

    // one more session start clears the last done flag
    if (!aborted && vec_index > 0) begin
      @(posedge avl_clk);
      #10;
      dma_xfer_req = 1'b1;
      @(posedge avl_clk);
      #10;
      test_errors = 0;
      flag_check("avl_xfer_req after the final session start", avl_xfer_req, 1'b0);
      dma_xfer_req = 1'b0;
      global_errors += test_errors;
    end

    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (!aborted && pass_count > 0 && fail_count == 0 && global_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+testbench
common/dacfifo_pkg.sv
beat_packer/beat_packer.sv
beat_packer/word_buffer.sv
source/avl_write_engine.sv
source/xfer_status.sv
source/dacfifo_wr_top.sv
testbench/tb_dacfifo_wr.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module tb_dacfifo_wr -Mdir obj_dir -f files.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vtb_dacfifo_wr > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the log decides the outcome
grep -q "Result: FAILED" sim.log
grep_status=$?
if [ $grep_status -eq 0 ]; then
  exit 1
fi
if [ $grep_status -ne 1 ]; then
  echo "could not search sim.log"
  exit 1
fi
exit 0

//--- testbench/dacfifo_vectors.txt
// columns: beat count, data seed, avl_ready stall percent, expected avl_last_address,
// expected avl_last_byteenable; all hex, a zero beat count ends the list
0001 1234abcd 00 0000000 000000ff
0002 0badf00d 00 0000000 0000ffff
0003 7e5c0011 0a 0000000 00ffffff
0004 00c0ffee 00 0000000 ffffffff
0005 31415926 19 0000001 000000ff
0006 00000001 5f 0000001 0000ffff
0007 27182818 19 0000001 00ffffff
0008 deadbeef 32 0000001 ffffffff
0009 55aa55aa 00 0000002 000000ff
000d 600dcafe 32 0000003 000000ff
0016 13579bdf 4b 0000005 0000ffff
001f 2468ace0 0a 0000007 00ffffff
0028 0f1e2d3c 3c 0000009 ffffffff
0032 a5a5c3c3 4b 000000c 0000ffff
0040 feedface 5a 000000f ffffffff
003d 8badf00d 5f 000000f 000000ff
0064 cafebabe 5a 0000018 ffffffff
0000 00000000 00 0000000 00000000
